// ==== common/mem_settings.svh ====
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// address and data word widths
`define MEM_ADDR_W 32
`define MEM_DATA_W 64

// direct-mapped cache with one 8-byte word per line
`define MEM_CACHE_LINES 16
`define MEM_INDEX_W 4

// store entries held before write-through
`define MEM_WBQ_DEPTH 4

`endif

// ==== common/mem_stage_pkg.sv ====
`default_nettype none

package mem_stage_pkg;

    typedef enum logic [1:0] {
        SIZE_BYTE,  // 1 byte
        SIZE_WORD,  // 2 bytes
        SIZE_DWORD, // 4 bytes
        SIZE_QWORD  // 8 bytes
    } access_size_e;

    typedef enum logic [2:0] {
        SRC_REG1,
        SRC_REG2,
        SRC_REG3,
        SRC_REG4,
        SRC_SEG,
        SRC_MEM, // last loaded data
        SRC_IMM,
        SRC_EIP
    } operand_src_e;

    typedef enum logic [1:0] {
        DEST_REG,
        DEST_SEG,
        DEST_MEM
    } dest_kind_e;

endpackage

`default_nettype wire

// ==== common/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    typedef enum logic [1:0] {
        C_IDLE,
        C_REFILL,  // waiting for the line from memory
        C_WRITE,   // write-through in flight
        C_RESPOND  // refilled load data goes out
    } cache_state_e;

    typedef enum logic {
        MEM_OP_READ,
        MEM_OP_WRITE
    } mem_op_e;

endpackage

`default_nettype wire

// ==== dcache/wb_queue.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mem_settings.svh"

module wb_queue (
    input  wire                                clk,
    input  wire                                arst_n,
    input  wire                                wb_valid,
    input  wire [`MEM_ADDR_W-1:0]              wb_addr,
    input  wire [`MEM_DATA_W-1:0]              wb_data,
    input  wire mem_stage_pkg::access_size_e   wb_size,
    input  wire                                pop,
    output logic                               head_valid,
    output logic [`MEM_ADDR_W-1:0]             head_addr,
    output logic [`MEM_DATA_W-1:0]             head_data,
    output mem_stage_pkg::access_size_e        head_size,
    output logic                               full,
    output logic                               empty
);
    import mem_stage_pkg::*;

    localparam int DEPTH = `MEM_WBQ_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [`MEM_ADDR_W-1:0] addr_mem [DEPTH];
    logic [`MEM_DATA_W-1:0] data_mem [DEPTH];
    access_size_e size_mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr, wr_ptr;
    logic [CNT_W-1:0] count;
    logic push, do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign push = wb_valid && !full; // a push into a full queue is lost
    assign do_pop = pop && !empty;
    assign empty = (count == '0);
    assign full = (count == CNT_W'(DEPTH));
    assign head_valid = !empty;
    assign head_addr = addr_mem[rd_ptr];
    assign head_data = data_mem[rd_ptr];
    assign head_size = size_mem[rd_ptr];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            addr_mem[wr_ptr] <= wb_addr;
            data_mem[wr_ptr] <= wb_data;
            size_mem[wr_ptr] <= wb_size;
        end
    end

endmodule

`default_nettype wire

// ==== dcache/dcache.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mem_settings.svh"

module dcache (
    input  wire                                clk,
    input  wire                                arst_n,
    input  wire                                load_req,
    input  wire [`MEM_ADDR_W-1:0]              load_addr,
    input  wire mem_stage_pkg::access_size_e   load_size,
    input  wire                                head_valid,
    input  wire [`MEM_ADDR_W-1:0]              head_addr,
    input  wire [`MEM_DATA_W-1:0]              head_data,
    input  wire mem_stage_pkg::access_size_e   head_size,
    input  wire                                wbq_empty,
    output logic                               pop,
    output logic                               cache_valid,
    output logic [`MEM_DATA_W-1:0]             cache_data,
    output logic                               cache_stall,
    output logic                               mem_req,
    output dcache_pkg::mem_op_e                mem_op,
    output logic [`MEM_ADDR_W-1:0]             mem_addr_out,
    output logic [`MEM_DATA_W-1:0]             mem_wdata,
    output logic [`MEM_DATA_W/8-1:0]           mem_be,
    input  wire                                mem_ack,
    input  wire [`MEM_DATA_W-1:0]              mem_rdata
);
    import mem_stage_pkg::*;
    import dcache_pkg::*;

    localparam int AW = `MEM_ADDR_W;
    localparam int DW = `MEM_DATA_W;
    localparam int IW = `MEM_INDEX_W;
    localparam int LINES = `MEM_CACHE_LINES;
    localparam int BE_W = DW / 8;
    localparam int OFF_W = $clog2(BE_W);
    localparam int TW = AW - IW - OFF_W;

    logic [TW-1:0] tag_arr [LINES];
    logic [DW-1:0] data_arr [LINES];
    logic [LINES-1:0] valid_arr;

    cache_state_e state;
    logic ld_pending; // accepted load held back by queued stores
    logic [AW-1:0] ld_addr;
    access_size_e ld_size;
    logic [AW-1:0] cur_addr;
    access_size_e cur_size;
    logic idle_like, take_load, take_store, cur_hit, st_hit;
    logic [IW-1:0] cur_idx, st_idx, ld_idx;
    logic [TW-1:0] cur_tag, st_tag, ld_tag;
    logic [BE_W-1:0] st_be;
    logic [DW-1:0] st_wdata;

    function automatic logic [DW-1:0] extract(input logic [DW-1:0] word,
                                              input logic [OFF_W-1:0] off,
                                              input access_size_e size);
        logic [DW-1:0] shifted;
        logic [DW-1:0] result;
        shifted = word >> {off, 3'b000};
        result = '0;
        case (size)
            SIZE_BYTE:  result[7:0] = shifted[7:0];
            SIZE_WORD:  result[15:0] = shifted[15:0];
            SIZE_DWORD: result[31:0] = shifted[31:0];
            default:    result = shifted;
        endcase
        return result;
    endfunction

    function automatic logic [BE_W-1:0] size_mask(input access_size_e size);
        case (size)
            SIZE_BYTE:  return 8'h01;
            SIZE_WORD:  return 8'h03;
            SIZE_DWORD: return 8'h0f;
            default:    return 8'hff;
        endcase
    endfunction

    assign idle_like = (state == C_IDLE) || (state == C_RESPOND);
    assign cur_addr = ld_pending ? ld_addr : load_addr;
    assign cur_size = ld_pending ? ld_size : load_size;
    assign take_load = idle_like && wbq_empty && (load_req || ld_pending);
    assign take_store = idle_like && head_valid && !load_req; // a new load wins the cycle
    assign pop = take_store;
    assign cache_stall = ld_pending || (state == C_REFILL);

    assign cur_idx = cur_addr[OFF_W +: IW];
    assign cur_tag = cur_addr[AW-1 -: TW];
    assign cur_hit = valid_arr[cur_idx] && (tag_arr[cur_idx] == cur_tag);
    assign st_idx = head_addr[OFF_W +: IW];
    assign st_tag = head_addr[AW-1 -: TW];
    assign st_hit = valid_arr[st_idx] && (tag_arr[st_idx] == st_tag);
    assign ld_idx = ld_addr[OFF_W +: IW];
    assign ld_tag = ld_addr[AW-1 -: TW];

    assign st_be = size_mask(head_size) << head_addr[OFF_W-1:0];
    assign st_wdata = head_data << {head_addr[OFF_W-1:0], 3'b000};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= C_IDLE;
            ld_pending <= 1'b0;
            cache_valid <= 1'b0;
            mem_req <= 1'b0;
            mem_op <= MEM_OP_READ;
            valid_arr <= '0;
        end else begin
            cache_valid <= 1'b0;
            if (load_req && !take_load) begin
                ld_pending <= 1'b1;
            end else if (take_load) begin
                ld_pending <= 1'b0;
            end
            case (state)
                C_IDLE, C_RESPOND: begin
                    if (take_load && cur_hit) begin
                        cache_valid <= 1'b1;
                        state <= C_IDLE;
                    end else if (take_load) begin
                        mem_req <= 1'b1;
                        mem_op <= MEM_OP_READ;
                        state <= C_REFILL;
                    end else if (take_store) begin
                        mem_req <= 1'b1;
                        mem_op <= MEM_OP_WRITE;
                        state <= C_WRITE;
                    end else begin
                        state <= C_IDLE;
                    end
                end
                C_REFILL: begin
                    if (mem_ack) begin
                        mem_req <= 1'b0;
                        valid_arr[ld_idx] <= 1'b1;
                        cache_valid <= 1'b1;
                        state <= C_RESPOND;
                    end
                end
                C_WRITE: begin
                    if (mem_ack) begin
                        mem_req <= 1'b0;
                        state <= C_IDLE;
                    end
                end
                default: state <= C_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load_req) begin
            ld_addr <= load_addr;
            ld_size <= load_size;
        end
        if (take_load && cur_hit) begin
            cache_data <= extract(data_arr[cur_idx], cur_addr[OFF_W-1:0], cur_size);
        end
        if (take_load && !cur_hit) begin
            mem_addr_out <= {cur_addr[AW-1:OFF_W], {OFF_W{1'b0}}};
            mem_be <= '1; // refill reads the whole word
        end
        if (state == C_REFILL && mem_ack) begin
            cache_data <= extract(mem_rdata, ld_addr[OFF_W-1:0], ld_size);
            tag_arr[ld_idx] <= ld_tag;
            data_arr[ld_idx] <= mem_rdata;
        end
        if (take_store) begin
            mem_addr_out <= {head_addr[AW-1:OFF_W], {OFF_W{1'b0}}};
            mem_wdata <= st_wdata;
            mem_be <= st_be;
            for (int b = 0; b < BE_W; b++) begin
                if (st_hit && st_be[b]) begin
                    data_arr[st_idx][b*8 +: 8] <= st_wdata[b*8 +: 8]; // no allocate on a miss
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/opswap.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mem_settings.svh"

module opswap (
    input  wire                                clk,
    input  wire                                arst_n,
    input  wire [`MEM_DATA_W-1:0]              reg1,
    input  wire [`MEM_DATA_W-1:0]              reg2,
    input  wire [`MEM_DATA_W-1:0]              reg3,
    input  wire [`MEM_DATA_W-1:0]              reg4,
    input  wire [15:0]                         seg,
    input  wire [`MEM_DATA_W-1:0]              imm,
    input  wire [`MEM_ADDR_W-1:0]              eip,
    input  wire                                cache_valid,
    input  wire [`MEM_DATA_W-1:0]              cache_data,
    input  wire mem_stage_pkg::operand_src_e   op1_sel,
    input  wire mem_stage_pkg::operand_src_e   op2_sel,
    output logic [`MEM_DATA_W-1:0]             op1_val,
    output logic [`MEM_DATA_W-1:0]             op2_val
);
    import mem_stage_pkg::*;

    localparam int DW = `MEM_DATA_W;

    logic [DW-1:0] mem_hold; // most recent load result

    function automatic logic [DW-1:0] pick(input operand_src_e sel);
        case (sel)
            SRC_REG1: return reg1;
            SRC_REG2: return reg2;
            SRC_REG3: return reg3;
            SRC_REG4: return reg4;
            SRC_SEG:  return DW'(seg);
            SRC_MEM:  return mem_hold;
            SRC_IMM:  return imm;
            default:  return DW'(eip);
        endcase
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_hold <= '0;
        end else if (cache_valid) begin
            mem_hold <= cache_data;
        end
    end

    always_comb begin
        op1_val = pick(op1_sel);
        op2_val = pick(op2_sel);
    end

endmodule

`default_nettype wire

// ==== logic/mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mem_settings.svh"

module mem_stage (
    input  wire                                clk,
    input  wire                                arst_n,
    input  wire                                valid_in,
    input  wire                                fwd_stall,
    input  wire mem_stage_pkg::access_size_e   opsize_in,
    input  wire [3:0]                          size_ovr,
    input  wire [`MEM_ADDR_W-1:0]              mem_addr,
    input  wire                                mem_rd,
    input  wire [`MEM_DATA_W-1:0]              reg1, reg2, reg3, reg4,
    input  wire [15:0]                         seg,
    input  wire [`MEM_DATA_W-1:0]              imm,
    input  wire [`MEM_ADDR_W-1:0]              eip,
    input  wire mem_stage_pkg::operand_src_e   op1_sel,
    input  wire mem_stage_pkg::operand_src_e   op2_sel,
    input  wire mem_stage_pkg::dest_kind_e     dest_sel,
    input  wire                                wb_valid,
    input  wire [`MEM_ADDR_W-1:0]              wb_addr,
    input  wire [`MEM_DATA_W-1:0]              wb_data,
    input  wire mem_stage_pkg::access_size_e   wb_size,
    output logic                               valid_out,
    output logic                               stall,
    output logic                               cache_valid,
    output logic [`MEM_DATA_W-1:0]             cache_data,
    output logic [`MEM_DATA_W-1:0]             op1_val, op2_val,
    output logic                               dest_is_reg, dest_is_seg, dest_is_mem,
    output logic                               wbq_full,
    output logic                               mem_req,
    output logic                               mem_op,
    output logic [`MEM_ADDR_W-1:0]             mem_addr_out,
    output logic [`MEM_DATA_W-1:0]             mem_wdata,
    output logic [`MEM_DATA_W/8-1:0]           mem_be,
    input  wire                                mem_ack,
    input  wire [`MEM_DATA_W-1:0]              mem_rdata
);
    import mem_stage_pkg::*;

    access_size_e size_to_use;
    logic cache_stall, load_req, pop, head_valid, wbq_empty;
    logic [`MEM_ADDR_W-1:0] head_addr;
    logic [`MEM_DATA_W-1:0] head_data;
    access_size_e head_size;

    // the lowest set override bit decides even when several bits are set
    always_comb begin
        if (size_ovr[0]) size_to_use = SIZE_BYTE;
        else if (size_ovr[1]) size_to_use = SIZE_WORD;
        else if (size_ovr[2]) size_to_use = SIZE_DWORD;
        else if (size_ovr[3]) size_to_use = SIZE_QWORD;
        else size_to_use = opsize_in;
    end

    assign stall = cache_stall | fwd_stall;
    assign valid_out = valid_in & ~stall;
    assign load_req = valid_in & mem_rd & ~stall;
    assign dest_is_reg = (dest_sel == DEST_REG);
    assign dest_is_seg = (dest_sel == DEST_SEG);
    assign dest_is_mem = (dest_sel == DEST_MEM);

    wb_queue u_wbq (.clk(clk), .arst_n(arst_n), .wb_valid(wb_valid), .wb_addr(wb_addr),
                    .wb_data(wb_data), .wb_size(wb_size), .pop(pop), .head_valid(head_valid),
                    .head_addr(head_addr), .head_data(head_data), .head_size(head_size),
                    .full(wbq_full), .empty(wbq_empty));

    dcache u_dcache (.clk(clk), .arst_n(arst_n), .load_req(load_req), .load_addr(mem_addr),
                     .load_size(size_to_use), .head_valid(head_valid), .head_addr(head_addr),
                     .head_data(head_data), .head_size(head_size), .wbq_empty(wbq_empty),
                     .pop(pop), .cache_valid(cache_valid), .cache_data(cache_data),
                     .cache_stall(cache_stall), .mem_req(mem_req), .mem_op(mem_op),
                     .mem_addr_out(mem_addr_out), .mem_wdata(mem_wdata), .mem_be(mem_be),
                     .mem_ack(mem_ack), .mem_rdata(mem_rdata));

    opswap u_opswap (.clk(clk), .arst_n(arst_n), .reg1(reg1), .reg2(reg2), .reg3(reg3),
                     .reg4(reg4), .seg(seg), .imm(imm), .eip(eip), .cache_valid(cache_valid),
                     .cache_data(cache_data), .op1_sel(op1_sel), .op2_sel(op2_sel),
                     .op1_val(op1_val), .op2_val(op2_val));

endmodule

`default_nettype wire

// ==== bench/backing_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mem_settings.svh"

module backing_mem_model (
    input  wire                          clk,
    input  wire                          arst_n,
    input  wire                          hold_ack,
    input  wire                          mem_req,
    input  wire                          mem_op,
    input  wire [`MEM_ADDR_W-1:0]        mem_addr_out,
    input  wire [`MEM_DATA_W-1:0]        mem_wdata,
    input  wire [`MEM_DATA_W/8-1:0]      mem_be,
    output logic                         mem_ack,
    output logic [`MEM_DATA_W-1:0]       mem_rdata
);
    import dcache_pkg::*;

    localparam int AW = `MEM_ADDR_W;
    localparam int BE_W = `MEM_DATA_W / 8;

    logic [7:0] bytes [logic [AW-1:0]]; // only bytes that were written are stored
    logic busy;
    int unsigned delay;

    function automatic logic [7:0] fill_byte(input logic [AW-1:0] a);
        return (a[7:0] * 8'd7) ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
    endfunction

    function automatic logic [7:0] read_byte(input logic [AW-1:0] a);
        return bytes.exists(a) ? bytes[a] : fill_byte(a);
    endfunction

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_ack <= 1'b0;
            busy <= 1'b0;
            delay <= 0;
            mem_rdata <= '0;
        end else begin
            mem_ack <= 1'b0;
            if (mem_req && !mem_ack) begin
                if (!busy) begin
                    busy <= 1'b1;
                    delay <= $urandom_range(6, 1) - 1; // ack after 1 to 6 cycles
                end else if (delay != 0) begin
                    delay <= delay - 1;
                end else if (!hold_ack) begin
                    busy <= 1'b0;
                    mem_ack <= 1'b1;
                    for (int b = 0; b < BE_W; b++) begin
                        if (mem_op == MEM_OP_WRITE && mem_be[b]) begin
                            bytes[mem_addr_out + AW'(b)] = mem_wdata[b*8 +: 8];
                        end
                        mem_rdata[b*8 +: 8] <= read_byte(mem_addr_out + AW'(b));
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== bench/mem_stage_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mem_settings.svh"

module mem_stage_tb;
    import mem_stage_pkg::*;

    localparam int AW = `MEM_ADDR_W;
    localparam int DW = `MEM_DATA_W;
    localparam int LD_MISS = 0;
    localparam int LD_HIT = 1;
    localparam int LD_ANY = 2;

    logic clk, arst_n, valid_in, fwd_stall, mem_rd, wb_valid, hold_ack;
    access_size_e opsize_in, wb_size;
    logic [3:0] size_ovr;
    logic [AW-1:0] mem_addr, wb_addr, eip;
    logic [DW-1:0] reg1, reg2, reg3, reg4, imm, wb_data;
    logic [15:0] seg;
    operand_src_e op1_sel, op2_sel;
    dest_kind_e dest_sel;
    wire valid_out, stall, cache_valid, dest_is_reg, dest_is_seg, dest_is_mem, wbq_full;
    wire mem_req, mem_op, mem_ack;
    wire [AW-1:0] mem_addr_out;
    wire [DW-1:0] cache_data, op1_val, op2_val, mem_wdata, mem_rdata;
    wire [DW/8-1:0] mem_be;

    logic load_busy; // set from the drive of a load until its cache_valid was seen
    logic [DW-1:0] last_load;
    logic [7:0] shadow [logic [AW-1:0]];
    bit seen_word [logic [AW-1:0]];
    logic [AW-1:0] exp_addr_q [$];
    logic [DW/8-1:0] exp_be_q [$];
    logic [DW-1:0] exp_data_q [$];

    mem_stage uut (.*);
    backing_mem_model mem_model (.*);

    always #20 clk = ~clk;

    task automatic report_mismatch(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic abort_run(input string msg);
        $display("%s at %0t ns", msg, $time);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic next_drive;
        @(posedge clk);
        #2;
    endtask

    function automatic logic [7:0] fill_byte(input logic [AW-1:0] a);
        return (a[7:0] * 8'd7) ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
    endfunction

    function automatic logic [7:0] mem_byte(input logic [AW-1:0] a);
        return shadow.exists(a) ? shadow[a] : fill_byte(a);
    endfunction

    // the lowest set override bit picks the size and the operand size applies without one
    function automatic int size_bytes(input access_size_e opsize, input logic [3:0] ovr);
        for (int i = 0; i < 4; i++) begin
            if (ovr[i]) begin
                return 1 << i;
            end
        end
        return 1 << int'(opsize);
    endfunction

    function automatic logic [DW-1:0] expected_load(input logic [AW-1:0] a, input int n);
        logic [DW-1:0] res;
        res = '0;
        for (int i = 0; i < n; i++) begin
            res[i*8 +: 8] = mem_byte(a + AW'(i));
        end
        return res;
    endfunction

    function automatic logic [DW-1:0] expected_operand(input operand_src_e sel);
        case (sel)
            SRC_REG1: return reg1;
            SRC_REG2: return reg2;
            SRC_REG3: return reg3;
            SRC_REG4: return reg4;
            SRC_SEG:  return {48'h0, seg};
            SRC_MEM:  return last_load;
            SRC_IMM:  return imm;
            default:  return {32'h0, eip};
        endcase
    endfunction

    // flag order is reg, seg, mem
    function automatic logic [2:0] expected_dest_flags(input dest_kind_e kind);
        case (kind)
            DEST_REG: return 3'b100;
            DEST_SEG: return 3'b010;
            DEST_MEM: return 3'b001;
            default:  return 3'b000;
        endcase
    endfunction

    function automatic logic [DW-1:0] be_bits(input logic [DW/8-1:0] be);
        logic [DW-1:0] m;
        for (int b = 0; b < DW / 8; b++) begin
            m[b*8 +: 8] = {8{be[b]}};
        end
        return m;
    endfunction

    function automatic logic [AW-1:0] random_cold_word();
        logic [AW-1:0] a;
        a = $urandom() & 32'h0000_fff8;
        while (seen_word.exists(a)) begin
            a = $urandom() & 32'h0000_fff8;
        end
        return a;
    endfunction

    task automatic do_load(input logic [AW-1:0] addr, input access_size_e opsize,
                           input logic [3:0] ovr, input int mode);
        int cycles;
        logic [DW-1:0] exp;
        next_drive();
        fwd_stall = 1'b0;
        valid_in = 1'b1;
        mem_rd = 1'b1;
        mem_addr = addr;
        opsize_in = opsize;
        size_ovr = ovr;
        load_busy = 1'b1;
        @(negedge clk);
        assert (!stall) else abort_run("Load could not be issued while the stage stalled");
        next_drive(); // the load was accepted at this edge
        valid_in = 1'b0;
        mem_rd = 1'b0;
        @(negedge clk);
        if (mode == LD_HIT) begin
            assert (cache_valid && !stall) else report_mismatch("hit did not answer next cycle");
        end else if (mode == LD_MISS) begin
            assert (stall && !cache_valid) else report_mismatch("cold load did not stall");
        end
        cycles = 0;
        while (!cache_valid) begin
            cycles++;
            if (cycles > 100) begin
                abort_run("Timeout waiting for cache_valid");
            end
            if (mode == LD_MISS) begin
                assert (stall) else report_mismatch("stall fell before the refill data");
            end
            @(negedge clk);
        end
        assert (!stall) else report_mismatch("stall still high with cache_valid");
        exp = expected_load(addr, size_bytes(opsize, ovr));
        assert (cache_data == exp) else report_mismatch(
            $sformatf("load at %h returned %h, expected %h", addr, cache_data, exp));
        last_load = exp;
        seen_word[{addr[AW-1:3], 3'b000}] = 1'b1;
        next_drive();
        load_busy = 1'b0;
    endtask

    task automatic random_load(input logic [AW-1:0] base, input int mode);
        access_size_e sz;
        logic [3:0] ovr;
        int n;
        sz = access_size_e'($urandom_range(3, 0));
        ovr = ($urandom_range(1, 0) == 1) ? 4'($urandom_range(15, 1)) : 4'h0;
        n = size_bytes(sz, ovr);
        do_load(base + AW'($urandom_range(8 - n, 0)), sz, ovr, mode);
    endtask

    task automatic push_store(input logic [AW-1:0] addr, input access_size_e size,
                              input logic [DW-1:0] data);
        int n;
        logic [DW/8-1:0] be;
        logic [DW-1:0] wd;
        n = 1 << int'(size);
        be = '0;
        wd = '0;
        for (int i = 0; i < n; i++) begin
            be[addr[2:0] + i] = 1'b1;
            wd[(addr[2:0] + i)*8 +: 8] = data[i*8 +: 8];
        end
        next_drive();
        assert (!wbq_full) else abort_run("Store queue was full before a push");
        wb_valid = 1'b1;
        wb_addr = addr;
        wb_size = size;
        wb_data = data;
        exp_addr_q.push_back({addr[AW-1:3], 3'b000});
        exp_be_q.push_back(be);
        exp_data_q.push_back(wd);
        next_drive();
        wb_valid = 1'b0;
    endtask

    task automatic random_store(input logic [AW-1:0] base);
        access_size_e sz;
        sz = access_size_e'($urandom_range(3, 0));
        push_store(base + AW'($urandom_range(8 - (1 << int'(sz)), 0)), sz,
                   {$urandom(), $urandom()});
    endtask

    task automatic store_then_load(input logic [AW-1:0] base);
        access_size_e sz;
        logic [AW-1:0] addr;
        logic [DW-1:0] data;
        logic [DW-1:0] mask;
        int n;
        sz = access_size_e'($urandom_range(3, 0));
        n = 1 << int'(sz);
        addr = base + AW'($urandom_range(8 - n, 0));
        data = {$urandom(), $urandom()};
        mask = '0;
        for (int i = 0; i < n; i++) begin
            mask[i*8 +: 8] = 8'hff;
        end
        push_store(addr, sz, data);
        do_load(addr, sz, 4'h0, LD_ANY);
        assert (last_load == (data & mask)) else report_mismatch(
            $sformatf("load after store at %h gave %h, stored %h", addr, last_load, data));
    endtask

    // stray valid_in and fwd_stall while the stores drain
    task automatic wait_drained;
        int cycles;
        cycles = 0;
        while (exp_addr_q.size() != 0) begin
            cycles++;
            if (cycles > 200) begin
                abort_run("Timeout waiting for the store queue to drain");
            end
            next_drive();
            fwd_stall = 1'($urandom_range(1, 0));
            valid_in = 1'($urandom_range(1, 0));
        end
        next_drive();
        fwd_stall = 1'b0;
        valid_in = 1'b0;
    endtask

    task automatic check_operands;
        for (int s = 0; s < 8; s++) begin
            next_drive();
            reg1 = {$urandom(), $urandom()};
            reg2 = {$urandom(), $urandom()};
            reg3 = {$urandom(), $urandom()};
            reg4 = {$urandom(), $urandom()};
            imm = {$urandom(), $urandom()};
            seg = 16'($urandom());
            eip = $urandom();
            op1_sel = operand_src_e'(s);
            op2_sel = operand_src_e'(7 - s);
            dest_sel = dest_kind_e'(s % 3);
            @(negedge clk);
            assert (op1_val == expected_operand(op1_sel) && op2_val == expected_operand(op2_sel))
                else report_mismatch($sformatf("operands for select %0d are %h and %h",
                                               s, op1_val, op2_val));
        end
    endtask

    // every acknowledged write must be the oldest queued store
    always @(posedge clk) begin
        if (arst_n && mem_req && mem_ack && mem_op) begin
            if (exp_addr_q.size() == 0) begin
                abort_run("A write appeared on the memory port with no store queued");
            end else begin
                assert (mem_addr_out == exp_addr_q[0] && mem_be == exp_be_q[0]
                        && (mem_wdata & be_bits(mem_be)) == exp_data_q[0])
                    else report_mismatch($sformatf("write %h be %h data %h, expected %h %h %h",
                        mem_addr_out, mem_be, mem_wdata, exp_addr_q[0], exp_be_q[0],
                        exp_data_q[0]));
                for (int b = 0; b < DW / 8; b++) begin
                    if (exp_be_q[0][b]) begin
                        shadow[exp_addr_q[0] + AW'(b)] = exp_data_q[0][b*8 +: 8];
                    end
                end
                void'(exp_addr_q.pop_front());
                void'(exp_be_q.pop_front());
                void'(exp_data_q.pop_front());
            end
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n) valid_out == (valid_in && !stall))
        else report_mismatch("valid_out differs from valid_in and not stall");
    assert property (@(posedge clk) disable iff (!arst_n) !load_busy |-> stall == fwd_stall)
        else report_mismatch("stall differs from fwd_stall with no load running");
    assert property (@(posedge clk) disable iff (!arst_n) cache_valid |=> !cache_valid)
        else report_mismatch("cache_valid lasted more than one cycle");
    assert property (@(posedge clk) disable iff (!arst_n) mem_req && !mem_ack |=>
                     mem_req && $stable(mem_addr_out) && $stable(mem_be) && $stable(mem_op)
                     && $stable(mem_wdata))
        else report_mismatch("memory request changed before its ack");
    assert property (@(posedge clk) disable iff (!arst_n) mem_ack |=> !mem_req)
        else report_mismatch("mem_req still high in the cycle after the ack");
    assert property (@(posedge clk) disable iff (!arst_n)
                     {dest_is_reg, dest_is_seg, dest_is_mem} == expected_dest_flags(dest_sel))
        else report_mismatch("destination flags do not match dest_sel");

    initial begin
        logic [AW-1:0] base;
        void'($urandom(32'hbb61));
        clk = 1'b0;
        arst_n = 1'b0;
        {valid_in, fwd_stall, mem_rd, wb_valid, hold_ack, load_busy} = '0;
        opsize_in = SIZE_BYTE;
        wb_size = SIZE_BYTE;
        size_ovr = 4'h0;
        {mem_addr, wb_addr, eip, seg} = '0;
        {reg1, reg2, reg3, reg4, imm, wb_data, last_load} = '0;
        op1_sel = SRC_REG1;
        op2_sel = SRC_REG2;
        dest_sel = DEST_REG;
        repeat (8) @(posedge clk);
        #2;
        arst_n = 1'b1;
        @(negedge clk);
        assert (!mem_req && !cache_valid && !stall && !wbq_full)
            else report_mismatch("outputs not idle after reset");
        check_operands(); // held load data reads as zero here
        for (int k = 0; k < 12; k++) begin
            base = random_cold_word();
            random_load(base, LD_MISS);
            random_load(base, LD_HIT); // the same line again which is now present
            wait_drained();
        end
        for (int k = 0; k < 6; k++) begin
            base = random_cold_word();
            if (k % 2 == 0) begin
                random_load(base, LD_MISS); // the line is present so the store updates it
            end
            random_store(random_cold_word());
            store_then_load(base);
        end
        wait_drained();
        next_drive();
        hold_ack = 1'b1;
        // the first store sits in the write that waits for mem_ack
        repeat (`MEM_WBQ_DEPTH + 1) begin
            random_store(random_cold_word());
        end
        assert (wbq_full) else report_mismatch("wbq_full not raised with mem_ack held off");
        next_drive();
        hold_ack = 1'b0;
        wait_drained();
        @(negedge clk);
        assert (!wbq_full) else report_mismatch("wbq_full still high after the drain");
        random_load(random_cold_word(), LD_MISS);
        check_operands();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+common
common/mem_stage_pkg.sv
common/dcache_pkg.sv
dcache/wb_queue.sv
dcache/dcache.sv
logic/opswap.sv
logic/mem_stage.sv
bench/backing_mem_model.sv
bench/mem_stage_tb.sv
